/* common/ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

    // ------------------------------------------------------------------------
    // Bus and pixel types
    // ------------------------------------------------------------------------
    typedef logic [19:0] addr_t;   // Shared bus byte address
    typedef logic [15:0] word_t;   // Bus data word
    typedef logic [11:0] color_t;  // 4 bits each of R, G, B

    // Layout of the picture data
    localparam int PALETTE_COUNT  = 8;
    localparam int PALETTE_COLORS = 16;
    localparam int TILE_BYTES     = 32;  // 8x8 pixels at 4 bpp
    localparam int MAP_SIDE       = 64;  // Background map is 64x64 tiles

    // Region bases in shared memory
    localparam addr_t PALETTE_OFFSET = 20'h00000;
    localparam addr_t TILE_OFFSET    = 20'h01000;
    localparam addr_t BG_MAP_OFFSET  = 20'h05000;

    // Shown wherever the tile nibble is 0
    localparam logic [7:0] SKY_R = 8'h88;
    localparam logic [7:0] SKY_G = 8'hDD;
    localparam logic [7:0] SKY_B = 8'hFF;

endpackage

`default_nettype wire

/* rtl/local_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module local_ram #(
    parameter  type entry_t   = logic [7:0],
    parameter  int DEPTH      = 256,
    parameter  int PAIR_WRITE = 0,   // 1 stores two entries per write
    localparam int AW         = $clog2(DEPTH)
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [AW-PAIR_WRITE-1:0] waddr,
    input  entry_t [PAIR_WRITE:0]    wdata,
    input  logic [AW-1:0]            raddr,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i <= PAIR_WRITE; i++) begin
                mem[(AW'(waddr) << PAIR_WRITE) | AW'(i)] <= wdata[i];
            end
        end
        rdata <= mem[raddr];  // One cycle read
    end

endmodule

`default_nettype wire

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter import ppu_pkg::*; #(
    parameter int BUS_READ_LATENCY = 1
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  cpu_bg_n,      // Bus grant from the 68000
    input  logic  cpu_as_n,      // Address strobe from the 68000
    input  logic  want_bus,
    input  logic  read_req,
    input  addr_t read_addr,
    input  word_t mem_rdata,
    output logic  ppu_br_n,
    output logic  ppu_bgack_n,
    output logic  cpu_bus_oe_n,  // High while the CPU drivers are off
    output addr_t mem_addr,
    output logic  mem_read,
    output logic  bus_ready,
    output logic  read_done,
    output word_t read_data
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_REQUEST,
        S_SEIZE,
        S_MASTER,
        S_READ,
        S_WAIT,
        S_RELEASE
    } state_t;

    state_t     state;
    logic [7:0] wait_cnt;
    logic       as_high_seen;  // Strobe was high on the previous sample

    assign bus_ready = (state == S_MASTER);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_IDLE;
            ppu_br_n     <= 1'b1;
            ppu_bgack_n  <= 1'b1;
            cpu_bus_oe_n <= 1'b0;
            mem_read     <= 1'b0;
            read_done    <= 1'b0;
            as_high_seen <= 1'b0;
            wait_cnt     <= '0;
        end else begin
            mem_read  <= 1'b0;
            read_done <= 1'b0;

            case (state)
                S_IDLE: begin
                    as_high_seen <= 1'b0;
                    if (want_bus) begin
                        ppu_br_n <= 1'b0;
                        state    <= S_REQUEST;
                    end
                end

                S_REQUEST: begin
                    as_high_seen <= cpu_as_n;
                    // Granted, and the CPU has finished its cycle
                    if (!cpu_bg_n && cpu_as_n && as_high_seen) begin
                        state <= S_SEIZE;
                    end
                end

                S_SEIZE: begin
                    ppu_bgack_n  <= 1'b0;
                    cpu_bus_oe_n <= 1'b1;
                    state        <= S_MASTER;
                end

                S_MASTER: begin
                    if (!want_bus) begin
                        state <= S_RELEASE;
                    end else if (read_req) begin
                        state <= S_READ;
                    end
                end

                S_READ: begin
                    mem_read <= 1'b1;  // Single-cycle strobe
                    wait_cnt <= '0;
                    state    <= S_WAIT;
                end

                S_WAIT: begin
                    if (wait_cnt == 8'(BUS_READ_LATENCY - 1)) begin
                        read_done <= 1'b1;
                        state     <= S_MASTER;
                    end else begin
                        wait_cnt <= wait_cnt + 8'd1;
                    end
                end

                S_RELEASE: begin
                    ppu_br_n     <= 1'b1;
                    ppu_bgack_n  <= 1'b1;
                    cpu_bus_oe_n <= 1'b0;  // Hand the bus back to the CPU
                    state        <= S_IDLE;
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    // Address and read data registers
    always_ff @(posedge clk) begin
        if (state == S_MASTER && want_bus && read_req) begin
            mem_addr <= read_addr;  // Held through the whole read
        end
        if (state == S_WAIT && wait_cnt == 8'(BUS_READ_LATENCY - 1)) begin
            read_data <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/refresh_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module refresh_sequencer import ppu_pkg::*; #(
    parameter  int TILE_COUNT = 256,
    localparam int PAL_WORDS  = PALETTE_COUNT * PALETTE_COLORS,
    localparam int TILE_WORDS = TILE_COUNT * TILE_BYTES / 2,
    localparam int MAP_WORDS  = MAP_SIDE * MAP_SIDE / 2,
    localparam int PAL_AW     = $clog2(PAL_WORDS),
    localparam int TILE_AW    = $clog2(TILE_WORDS),
    localparam int MAP_AW     = $clog2(MAP_WORDS)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               refresh_start,
    input  logic               bus_ready,
    input  logic               read_done,
    input  word_t              read_data,
    output logic               want_bus,
    output logic               read_req,
    output addr_t              read_addr,
    output logic               refresh_done,
    output logic               pal_we,
    output logic               tile_we,
    output logic               map_we,
    output logic [PAL_AW-1:0]  pal_waddr,
    output logic [TILE_AW-1:0] tile_waddr,
    output logic [MAP_AW-1:0]  map_waddr,
    output color_t             pal_wdata,
    output logic [15:0]        byte_wdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } state_t;

    typedef enum logic [1:0] {
        R_PAL,
        R_TILE,
        R_MAP
    } region_t;

    state_t      state;
    region_t     region;
    logic [15:0] word_cnt;
    logic [15:0] last_word;
    addr_t       region_base;
    logic        stored;

    // ------------------------------------------------------------------------
    // Region decode
    // ------------------------------------------------------------------------
    always_comb begin
        case (region)
            R_PAL: begin
                region_base = PALETTE_OFFSET;
                last_word   = 16'(PAL_WORDS - 1);
            end
            R_TILE: begin
                region_base = TILE_OFFSET;
                last_word   = 16'(TILE_WORDS - 1);
            end
            default: begin
                region_base = BG_MAP_OFFSET;
                last_word   = 16'(MAP_WORDS - 1);
            end
        endcase
    end

    assign read_addr = region_base + addr_t'({word_cnt, 1'b0});  // Word to byte address
    assign read_req  = (state == S_ISSUE) && bus_ready;
    assign stored    = (state == S_WAIT) && read_done;

    // Write side of the local memories
    assign pal_we     = stored && (region == R_PAL);
    assign tile_we    = stored && (region == R_TILE);
    assign map_we     = stored && (region == R_MAP);
    assign pal_waddr  = word_cnt[PAL_AW-1:0];
    assign tile_waddr = word_cnt[TILE_AW-1:0];
    assign map_waddr  = word_cnt[MAP_AW-1:0];
    assign pal_wdata  = read_data[11:0];
    assign byte_wdata = read_data;  // Low byte lands on the even address

    // ------------------------------------------------------------------------
    // Region walk
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= S_IDLE;
            region       <= R_PAL;
            word_cnt     <= '0;
            want_bus     <= 1'b0;
            refresh_done <= 1'b0;
        end else begin
            refresh_done <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (refresh_start) begin
                        want_bus <= 1'b1;
                        region   <= R_PAL;
                        word_cnt <= '0;
                        state    <= S_ISSUE;
                    end
                end

                S_ISSUE: begin
                    if (bus_ready) begin
                        state <= S_WAIT;  // Request went out this cycle
                    end
                end

                S_WAIT: begin
                    if (read_done) begin
                        state <= S_ISSUE;
                        if (word_cnt != last_word) begin
                            word_cnt <= word_cnt + 16'd1;
                        end else begin
                            word_cnt <= '0;
                            case (region)
                                R_PAL:  region <= R_TILE;
                                R_TILE: region <= R_MAP;
                                default: begin
                                    // Map done, frame data complete
                                    want_bus     <= 1'b0;
                                    refresh_done <= 1'b1;
                                    state        <= S_IDLE;
                                end
                            endcase
                        end
                    end
                end

                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* render/bg_tile_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module bg_tile_fetch import ppu_pkg::*; #(
    parameter  int DISP_WIDTH  = 320,
    parameter  int DISP_HEIGHT = 240,
    localparam int XW          = $clog2(DISP_WIDTH),
    localparam int YW          = $clog2(DISP_HEIGHT)
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        refresh_done,
    input  logic [7:0]  map_rdata,     // Tile index of the current map cell
    output logic        refresh_start,
    output logic [11:0] map_raddr,
    output logic [12:0] tile_raddr,
    output logic        nibble_sel,
    output logic        fetch_valid
);

    localparam int MW = $clog2(MAP_SIDE);

    logic [XW-1:0] pixel_x;
    logic [YW-1:0] pixel_y;
    logic          frame_ready;  // Local memories hold this frame
    logic          refreshing;
    logic          at_origin;
    logic [2:0]    row_q;
    logic [1:0]    col_q;

    assign at_origin     = (pixel_x == '0) && (pixel_y == '0);
    assign refresh_start = at_origin && !frame_ready && !refreshing;

    // 64 tiles per map row
    assign map_raddr = {MW'(pixel_y >> 3), MW'(pixel_x >> 3)};

    // ------------------------------------------------------------------------
    // Raster counter and frame control
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pixel_x     <= '0;
            pixel_y     <= '0;
            frame_ready <= 1'b0;
            refreshing  <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= frame_ready;
            if (refresh_start) begin
                refreshing <= 1'b1;
            end else if (refresh_done) begin
                refreshing  <= 1'b0;
                frame_ready <= 1'b1;
            end

            if (frame_ready) begin  // Counter holds during a refresh
                if (pixel_x == XW'(DISP_WIDTH - 1)) begin
                    pixel_x <= '0;
                    if (pixel_y == YW'(DISP_HEIGHT - 1)) begin
                        pixel_y     <= '0;
                        frame_ready <= 1'b0;  // Next frame needs fresh data
                    end else begin
                        pixel_y <= pixel_y + 1'b1;
                    end
                end else begin
                    pixel_x <= pixel_x + 1'b1;
                end
            end
        end
    end

    // Pixel phase travels alongside the map read
    always_ff @(posedge clk) begin
        row_q      <= pixel_y[2:0];
        col_q      <= pixel_x[2:1];
        nibble_sel <= pixel_x[0];
    end

    // Index * 32 + row * 4 + column / 2
    assign tile_raddr = 13'(map_rdata) * 13'(TILE_BYTES) + 13'({row_q, 2'b00}) + 13'(col_q);

endmodule

`default_nettype wire

/* render/pixel_colorize.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_colorize import ppu_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tile_rdata,   // Two pixels, even one in the high nibble
    input  logic       nibble_sel,
    input  logic       fetch_valid,
    input  logic [2:0] bg_palette,
    input  color_t     pal_rdata,
    output logic [6:0] pal_raddr,
    output logic [7:0] pixel_r,
    output logic [7:0] pixel_g,
    output logic [7:0] pixel_b,
    output logic       pixel_sync
);

    logic       sel_q;
    logic       valid_q;
    logic       zero_q;
    logic       valid_qq;
    logic [3:0] nibble;

    assign nibble    = sel_q ? tile_rdata[3:0] : tile_rdata[7:4];
    assign pal_raddr = {bg_palette, nibble};

    // ------------------------------------------------------------------------
    // Valid chain, matched to the tile and palette reads
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            valid_qq   <= 1'b0;
            pixel_sync <= 1'b0;
        end else begin
            valid_q    <= fetch_valid;
            valid_qq   <= valid_q;
            pixel_sync <= valid_qq;
        end
    end

    always_ff @(posedge clk) begin
        sel_q  <= nibble_sel;
        zero_q <= (nibble == 4'd0);  // Ready together with pal_rdata

        if (zero_q) begin
            pixel_r <= SKY_R;
            pixel_g <= SKY_G;
            pixel_b <= SKY_B;
        end else begin
            pixel_r <= {2{pal_rdata[11:8]}};
            pixel_g <= {2{pal_rdata[7:4]}};
            pixel_b <= {2{pal_rdata[3:0]}};
        end
    end

endmodule

`default_nettype wire

/* rtl/ppu.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu import ppu_pkg::*; #(
    parameter int DISP_WIDTH       = 320,
    parameter int DISP_HEIGHT      = 240,
    parameter int TILE_COUNT       = 256,
    parameter int BUS_READ_LATENCY = 1
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       cpu_bg_n,
    input  logic       cpu_as_n,
    input  word_t      mem_rdata,
    input  logic [2:0] bg_palette,
    output logic       ppu_br_n,
    output logic       ppu_bgack_n,
    output logic       cpu_bus_oe_n,
    output logic       mem_read,
    output addr_t      mem_addr,
    output logic [7:0] pixel_r,
    output logic [7:0] pixel_g,
    output logic [7:0] pixel_b,
    output logic       pixel_sync
);

    localparam int PAL_DEPTH  = PALETTE_COUNT * PALETTE_COLORS;
    localparam int TILE_DEPTH = TILE_COUNT * TILE_BYTES;
    localparam int MAP_DEPTH  = MAP_SIDE * MAP_SIDE;
    localparam int TILE_AW    = $clog2(TILE_DEPTH);

    // Refresh chain
    logic                 want_bus;
    logic                 bus_ready;
    logic                 read_req;
    logic                 read_done;
    addr_t                read_addr;
    word_t                read_data;
    logic                 refresh_start;
    logic                 refresh_done;
    logic                 pal_we;
    logic                 tile_we;
    logic                 map_we;
    logic [6:0]           pal_waddr;
    logic [TILE_AW-2:0]   tile_waddr;
    logic [10:0]          map_waddr;
    color_t               pal_wdata;
    logic [15:0]          byte_wdata;

    // Render chain
    logic [11:0]          map_raddr;
    logic [7:0]           map_rdata;
    logic [12:0]          tile_raddr;
    logic [7:0]           tile_rdata;
    logic [6:0]           pal_raddr;
    color_t               pal_rdata;
    logic                 nibble_sel;
    logic                 fetch_valid;

    // ------------------------------------------------------------------------
    // Bus side
    // ------------------------------------------------------------------------
    bus_arbiter #(.BUS_READ_LATENCY(BUS_READ_LATENCY)) u_arbiter (
        .clk, .reset, .cpu_bg_n, .cpu_as_n, .want_bus, .read_req, .read_addr,
        .mem_rdata, .ppu_br_n, .ppu_bgack_n, .cpu_bus_oe_n, .mem_addr, .mem_read,
        .bus_ready, .read_done, .read_data
    );

    refresh_sequencer #(.TILE_COUNT(TILE_COUNT)) u_sequencer (
        .clk, .reset, .refresh_start, .bus_ready, .read_done, .read_data,
        .want_bus, .read_req, .read_addr, .refresh_done, .pal_we, .tile_we,
        .map_we, .pal_waddr, .tile_waddr, .map_waddr, .pal_wdata, .byte_wdata
    );

    // ------------------------------------------------------------------------
    // Local memories
    // ------------------------------------------------------------------------
    local_ram #(.entry_t(color_t), .DEPTH(PAL_DEPTH), .PAIR_WRITE(0)) u_pal_ram (
        .clk, .we(pal_we), .waddr(pal_waddr), .wdata(pal_wdata),
        .raddr(pal_raddr), .rdata(pal_rdata)
    );

    local_ram #(.entry_t(logic [7:0]), .DEPTH(TILE_DEPTH), .PAIR_WRITE(1)) u_tile_ram (
        .clk, .we(tile_we), .waddr(tile_waddr), .wdata(byte_wdata),
        .raddr(tile_raddr[TILE_AW-1:0]), .rdata(tile_rdata)  // Map entries stay below TILE_COUNT
    );

    local_ram #(.entry_t(logic [7:0]), .DEPTH(MAP_DEPTH), .PAIR_WRITE(1)) u_map_ram (
        .clk, .we(map_we), .waddr(map_waddr), .wdata(byte_wdata),
        .raddr(map_raddr), .rdata(map_rdata)
    );

    // ------------------------------------------------------------------------
    // Background pipeline
    // ------------------------------------------------------------------------
    bg_tile_fetch #(.DISP_WIDTH(DISP_WIDTH), .DISP_HEIGHT(DISP_HEIGHT)) u_fetch (
        .clk, .reset, .refresh_done, .map_rdata, .refresh_start, .map_raddr,
        .tile_raddr, .nibble_sel, .fetch_valid
    );

    pixel_colorize u_colorize (
        .clk, .reset, .tile_rdata, .nibble_sel, .fetch_valid, .bg_palette,
        .pal_rdata, .pal_raddr, .pixel_r, .pixel_g, .pixel_b, .pixel_sync
    );

endmodule

`default_nettype wire

/* testbench/ppu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_assertions (
    input logic clk,
    input logic reset,
    input logic ppu_br_n,
    input logic ppu_bgack_n,
    input logic cpu_bus_oe_n,
    input logic mem_read
);

    // ------------------------------------------------------------------------
    // Bus ownership rules of the arbiter
    // ------------------------------------------------------------------------

    // Reads only while the PPU owns the bus
    read_needs_ownership: assert property (
        @(posedge clk) disable iff (reset)
        mem_read |-> !ppu_bgack_n
    ) else $error("mem_read high while ppu_bgack_n is high");

    // CPU drivers are off exactly while the PPU owns the bus
    oe_follows_bgack: assert property (
        @(posedge clk) disable iff (reset)
        cpu_bus_oe_n == !ppu_bgack_n
    ) else $error("cpu_bus_oe_n does not match the inverse of ppu_bgack_n");

    // Seizing needs an outstanding request
    bgack_needs_request: assert property (
        @(posedge clk) disable iff (reset)
        $fell(ppu_bgack_n) |-> !ppu_br_n
    ) else $error("ppu_bgack_n fell while ppu_br_n was high");

endmodule

`default_nettype wire

/* testbench/tb_ppu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ppu import ppu_pkg::*; ();

    localparam int DISP_WIDTH       = 32;
    localparam int DISP_HEIGHT      = 16;
    localparam int TILE_COUNT       = 16;
    localparam int BUS_READ_LATENCY = 2;
    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 8;
    localparam int PAL_WORDS        = PALETTE_COUNT * PALETTE_COLORS;
    localparam int TILE_WORDS       = TILE_COUNT * TILE_BYTES / 2;
    localparam int MAP_WORDS        = MAP_SIDE * MAP_SIDE / 2;
    localparam int REFRESH_READS    = PAL_WORDS + TILE_WORDS + MAP_WORDS;
    localparam int MEM_WORDS        = int'(BG_MAP_OFFSET) / 2 + MAP_WORDS;
    localparam int FRAME_PIXELS     = DISP_WIDTH * DISP_HEIGHT;
    localparam int SEIZE_TIMEOUT    = 500;
    localparam int LONG_TIMEOUT     = 40000;  // Cycles, covers a whole refresh

    logic       clk;
    logic       reset;
    logic       cpu_bg_n = 1'b1;
    logic       cpu_as_n = 1'b1;
    word_t      mem_rdata = '0;
    logic [2:0] bg_palette;
    logic       ppu_br_n;
    logic       ppu_bgack_n;
    logic       cpu_bus_oe_n;
    logic       mem_read;
    addr_t      mem_addr;
    logic [7:0] pixel_r;
    logic [7:0] pixel_g;
    logic [7:0] pixel_b;
    logic       pixel_sync;

    word_t       shmem [MEM_WORDS];   // Shared 68000 memory
    addr_t       read_log [$];
    logic [23:0] pixel_log [$];
    logic [2:0]  as_hist;             // Strobe seen at the last three rising edges
    logic [1:0]  bg_hist;
    logic        hold_grant = 1'b0;
    logic        timed_out = 1'b0;
    int          error_count = 0;
    int          check_count = 0;
    int          as_count;
    int          grant_count;
    int          pend_count;
    logic        pending = 1'b0;
    addr_t       pend_addr;

    ppu #(
        .DISP_WIDTH(DISP_WIDTH), .DISP_HEIGHT(DISP_HEIGHT),
        .TILE_COUNT(TILE_COUNT), .BUS_READ_LATENCY(BUS_READ_LATENCY)
    ) DUT (
        .clk, .reset, .cpu_bg_n, .cpu_as_n, .mem_rdata, .bg_palette, .ppu_br_n,
        .ppu_bgack_n, .cpu_bus_oe_n, .mem_read, .mem_addr, .pixel_r, .pixel_g,
        .pixel_b, .pixel_sync
    );

    bind bus_arbiter ppu_assertions u_bus_rules (
        .clk, .reset, .ppu_br_n, .ppu_bgack_n, .cpu_bus_oe_n, .mem_read
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // CPU, memory and output monitors
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            cpu_as_n    = 1'b1;
            cpu_bg_n    = 1'b1;
            as_count    = 2;
            grant_count = 4;
        end else begin
            if (!ppu_bgack_n) begin
                cpu_as_n = 1'b1;  // CPU is off the bus
            end else if (as_count == 0) begin
                cpu_as_n = ~cpu_as_n;
                as_count = $urandom_range(1, 6);
            end else begin
                as_count--;
            end
            if (ppu_br_n) begin
                cpu_bg_n    = 1'b1;
                grant_count = $urandom_range(2, 10);
            end else if (!hold_grant) begin
                if (grant_count == 0) cpu_bg_n = 1'b0;
                else grant_count--;
            end
        end
    end

    // Data valid on the BUS_READ_LATENCY-th edge after mem_read rose
    always @(negedge clk) begin
        if (mem_read) begin
            pend_addr  = mem_addr;
            pend_count = BUS_READ_LATENCY - 1;
            pending    = 1'b1;
        end else if (pending) begin
            pend_count--;
        end
        if (pending && pend_count == 0) begin
            mem_rdata = shmem[int'(pend_addr) / 2];
            pending   = 1'b0;
        end else begin
            mem_rdata = word_t'($urandom);  // Bus noise
        end
    end

    always @(negedge clk) begin
        if (mem_read) read_log.push_back(mem_addr);
        if (pixel_sync) pixel_log.push_back({pixel_r, pixel_g, pixel_b});
    end

    always @(posedge clk) begin
        as_hist <= {as_hist[1:0], cpu_as_n};
        bg_hist <= {bg_hist[0], cpu_bg_n};
    end

    // ------------------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------------------
    task automatic compare_value(string name, logic [31:0] got, logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic note_timeout(string what);
        $display("Timeout while waiting for %s", what);
        timed_out = 1'b1;
    endtask

    task automatic fill_memory();
        int map_base;
        map_base = int'(BG_MAP_OFFSET) / 2;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shmem[i] = word_t'($urandom);
        end
        for (int i = 0; i < MAP_WORDS; i++) begin  // Tile indices stay in range
            shmem[map_base + i] = {8'($urandom % TILE_COUNT), 8'($urandom % TILE_COUNT)};
        end
    endtask

    function automatic logic [7:0] region_byte(int base_word, int index);
        word_t w;
        w = shmem[base_word + index / 2];
        return (index % 2 == 0) ? w[7:0] : w[15:8];
    endfunction

    function automatic addr_t refresh_address(int k);
        if (k < PAL_WORDS) return PALETTE_OFFSET + addr_t'(2 * k);
        if (k < PAL_WORDS + TILE_WORDS) return TILE_OFFSET + addr_t'(2 * (k - PAL_WORDS));
        return BG_MAP_OFFSET + addr_t'(2 * (k - PAL_WORDS - TILE_WORDS));
    endfunction

    function automatic logic [23:0] expected_pixel(int x, int y, logic [2:0] palette);
        int         tile;
        int         tile_byte;
        logic [7:0] pair;
        logic [3:0] nib;
        color_t     color;
        tile      = int'(region_byte(int'(BG_MAP_OFFSET) / 2, (y / 8) * MAP_SIDE + x / 8));
        tile_byte = tile * TILE_BYTES + (y % 8) * 4 + (x % 8) / 2;
        pair      = region_byte(int'(TILE_OFFSET) / 2, tile_byte);
        nib       = (x % 2 == 0) ? pair[7:4] : pair[3:0];
        if (nib == 4'd0) return {SKY_R, SKY_G, SKY_B};
        color = shmem[int'(PALETTE_OFFSET) / 2 + int'(palette) * PALETTE_COLORS + int'(nib)][11:0];
        return {{2{color[11:8]}}, {2{color[7:4]}}, {2{color[3:0]}}};
    endfunction

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic reset_outputs_idle();
        compare_value("ppu_br_n", 32'(ppu_br_n), 32'd1);
        compare_value("ppu_bgack_n", 32'(ppu_bgack_n), 32'd1);
        compare_value("cpu_bus_oe_n", 32'(cpu_bus_oe_n), 32'd0);
        compare_value("mem_read", 32'(mem_read), 32'd0);
        compare_value("pixel_sync", 32'(pixel_sync), 32'd0);
    endtask

    task automatic bus_seize_timing();
        int   waited;
        logic prev_bgack;
        waited = 0;
        while (!timed_out) begin
            prev_bgack = ppu_bgack_n;
            @(negedge clk);
            if (prev_bgack && !ppu_bgack_n) break;
            waited++;
            if (waited >= SEIZE_TIMEOUT) note_timeout("the PPU to seize the bus");
        end
        if (timed_out) return;
        // Decision edge is one edge before bgack_n fell
        compare_value("cpu_bg_n at seize", 32'(bg_hist[1]), 32'd0);
        compare_value("cpu_as_n at seize", 32'(as_hist[1]), 32'd1);
        compare_value("cpu_as_n before seize", 32'(as_hist[2]), 32'd1);
        compare_value("ppu_br_n", 32'(ppu_br_n), 32'd0);
        compare_value("cpu_bus_oe_n", 32'(cpu_bus_oe_n), 32'd1);
    endtask

    task automatic refresh_read_order();
        int waited;
        waited = 0;
        while (!ppu_bgack_n && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited >= LONG_TIMEOUT) note_timeout("the bus release after the refresh");
        end
        if (timed_out) return;
        hold_grant = 1'b1;  // Next refresh stays off the bus for now
        compare_value("ppu_br_n", 32'(ppu_br_n), 32'd1);
        compare_value("cpu_bus_oe_n", 32'(cpu_bus_oe_n), 32'd0);
        compare_value("refresh read count", 32'(read_log.size()), 32'(REFRESH_READS));
        for (int k = 0; k < read_log.size() && k < REFRESH_READS; k++) begin
            if (read_log[k] !== refresh_address(k)) begin
                compare_value($sformatf("mem_addr[read %0d]", k), 32'(read_log[k]),
                              32'(refresh_address(k)));
                break;
            end
        end
        read_log.delete();
    endtask

    task automatic frame_pixels(string label);
        int          waited;
        logic [23:0] got;
        waited = 0;
        while (pixel_log.size() < FRAME_PIXELS && !timed_out) begin
            @(negedge clk);
            waited++;
            if (waited >= LONG_TIMEOUT) note_timeout({label, " pixels"});
        end
        if (timed_out) return;
        for (int i = 0; i < FRAME_PIXELS; i++) begin
            got = pixel_log.pop_front();
            compare_value($sformatf("pixel_rgb[%s %0d]", label, i), 32'(got),
                          32'(expected_pixel(i % DISP_WIDTH, i / DISP_WIDTH, bg_palette)));
        end
    endtask

    task automatic second_frame_update();
        fill_memory();     // New contents while the grant is withheld
        bg_palette = 3'd2;
        hold_grant = 1'b0;
        frame_pixels("frame 2");
    endtask

    initial begin
        void'($urandom(32'hb2f6_838f));
        reset      = 1'b1;
        bg_palette = 3'd5;
        fill_memory();
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        reset_outputs_idle();
        bus_seize_timing();
        if (!timed_out) refresh_read_order();
        if (!timed_out) frame_pixels("frame 1");
        if (!timed_out) second_frame_update();

        $display("Checks: %0d  errors: %0d  timeouts: %0d", check_count, error_count,
                 32'(timed_out));
        if (error_count == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* ppu.f */
common/ppu_pkg.sv
rtl/local_ram.sv
rtl/bus_arbiter.sv
rtl/refresh_sequencer.sv
render/bg_tile_fetch.sv
render/pixel_colorize.sv
rtl/ppu.sv
testbench/ppu_assertions.sv
testbench/tb_ppu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the PPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_ppu \
    -Mdir obj_dir -f ppu.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_ppu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" "$LOG"; then
    exit 0
fi
echo "Simulation did not pass"
exit 1
